// File: common/wsn_pkg.sv
package wsn_pkg;

    // width of every numeric packet field
    localparam int WORD_W = 16;

    // width of the packet type code
    localparam int TYPE_W = 3;

    // packet kinds seen on the radio side
    typedef enum logic [TYPE_W-1:0] {
        PKT_HEARTBEAT = 3'd0,
        PKT_CH_ADV    = 3'd1,
        PKT_JOIN      = 3'd2,
        PKT_SCHED     = 3'd4,
        PKT_DATA      = 3'd5
    } pkt_type_e;

    // one framed packet, 115 bits
    // fields a packet kind does not use are don't-care
    // data packets carry payload in timeslot and e_threshold
    typedef struct packed {
        pkt_type_e           pkt_type;
        logic [WORD_W-1:0]   src_id;
        logic [WORD_W-1:0]   ch_id;
        logic [WORD_W-1:0]   hops;
        logic [WORD_W-1:0]   timeslot;
        logic [WORD_W-1:0]   e_min;
        logic [WORD_W-1:0]   e_max;
        // heartbeat only
        logic [WORD_W-1:0]   e_threshold;
    } wsn_pkt_t;

    // latched heartbeat state handed to the Q block
    typedef struct packed {
        logic [WORD_W-1:0]   e_min;
        logic [WORD_W-1:0]   e_max;
        logic [WORD_W-1:0]   hops_from_sink;
    } node_cfg_t;

endpackage

// File: verilog/pkt_rx_queue.sv
`timescale 1ns/1ps

module pkt_rx_queue #(
    parameter int RX_DEPTH       = 4,
    parameter int TX_CREDITS_MAX = 4
) (
    input  logic              clk,
    input  logic              nrst,
    input  logic              rx_valid,
    input  wsn_pkg::wsn_pkt_t rx_pkt,
    output logic              rx_credit,
    input  logic              tx_credit,
    output logic              tx_valid,
    output wsn_pkg::wsn_pkt_t tx_pkt,
    output logic              disp_valid,
    output wsn_pkg::wsn_pkt_t disp_pkt
);
    import wsn_pkg::*;

    localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
    localparam int CNT_W = $clog2(RX_DEPTH + 1);
    localparam int TXC_W = $clog2(TX_CREDITS_MAX + 1);

    wsn_pkt_t             mem [RX_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;
    logic [TXC_W-1:0]     tx_cnt;

    wsn_pkt_t             head;
    logic                 head_is_data;
    logic                 pop;
    logic                 send;

    // head may leave unless it is data and no tx credit is left
    assign head         = mem[rd_ptr];
    assign head_is_data = (head.pkt_type == PKT_DATA);
    assign pop          = (count != '0) && (!head_is_data || (tx_cnt != '0));
    assign send         = pop && head_is_data;

    // storage, no reset
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            mem[wr_ptr] <= rx_pkt;
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (rx_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({rx_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // tx credits, a return and a send in one cycle cancel out
    always_ff @(posedge clk) begin
        if (!nrst) begin
            tx_cnt <= TXC_W'(TX_CREDITS_MAX);
        end else begin
            case ({tx_credit, send})
                2'b10:   tx_cnt <= tx_cnt + 1'b1;
                2'b01:   tx_cnt <= tx_cnt - 1'b1;
                default: tx_cnt <= tx_cnt;
            endcase
        end
    end

    // strobes registered at the pop edge
    // joins pop silently, data also goes to node_info to end the round
    always_ff @(posedge clk) begin
        if (!nrst) begin
            rx_credit  <= 1'b0;
            tx_valid   <= 1'b0;
            disp_valid <= 1'b0;
        end else begin
            rx_credit  <= pop;
            tx_valid   <= send;
            disp_valid <= pop && (head.pkt_type != PKT_JOIN);
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            tx_pkt <= head;
        end
        if (pop) begin
            disp_pkt <= head;
        end
    end

    // sender must hold a credit, so the FIFO is never full on push
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!nrst)
        rx_valid |-> (count != CNT_W'(RX_DEPTH))
    );

    // forwarded beat only when a credit was there to spend
    a_tx_has_credit: assert property (
        @(posedge clk) disable iff (!nrst)
        tx_valid |-> ($past(tx_cnt) != '0)
    );

    // next hop never returns more than it was given
    a_tx_credit_max: assert property (
        @(posedge clk) disable iff (!nrst)
        tx_cnt <= TXC_W'(TX_CREDITS_MAX)
    );

endmodule

// File: node_info/node_info.sv
`timescale 1ns/1ps

module node_info #(
    parameter logic [wsn_pkg::WORD_W-1:0] NODE_ID = 16'h000C
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  logic                         disp_valid,
    input  wsn_pkg::wsn_pkt_t            disp_pkt,
    input  logic [wsn_pkg::WORD_W-1:0]   energy,
    output wsn_pkg::node_cfg_t           cfg,
    output logic [wsn_pkg::WORD_W-1:0]   hops_from_sink,
    output logic [wsn_pkg::WORD_W-1:0]   timeslot,
    output logic                         role,
    output logic                         low_energy
);
    import wsn_pkg::*;

    logic                 hb_lock;
    logic [WORD_W-1:0]    e_min_r;
    logic [WORD_W-1:0]    e_max_r;
    logic [WORD_W-1:0]    e_threshold_r;

    logic                 is_hb;
    logic                 is_ch_adv;
    logic                 is_sched;
    logic                 is_data;
    logic                 hb_load;

    // decode of the dispatched packet
    assign is_hb     = disp_valid && (disp_pkt.pkt_type == PKT_HEARTBEAT);
    assign is_ch_adv = disp_valid && (disp_pkt.pkt_type == PKT_CH_ADV);
    assign is_sched  = disp_valid && (disp_pkt.pkt_type == PKT_SCHED);
    assign is_data   = disp_valid && (disp_pkt.pkt_type == PKT_DATA);

    // only the first heartbeat of a round is taken
    assign hb_load = is_hb && !hb_lock;

    // heartbeat lock, released when data shows the round has moved on
    always_ff @(posedge clk) begin
        if (!nrst) begin
            hb_lock <= 1'b0;
        end else if (hb_load) begin
            hb_lock <= 1'b1;
        end else if (is_data) begin
            hb_lock <= 1'b0;
        end
    end

    // heartbeat fields
    // threshold comes from its own field
    always_ff @(posedge clk) begin
        if (!nrst) begin
            hops_from_sink <= '0;
            e_min_r        <= '0;
            e_max_r        <= '0;
            e_threshold_r  <= '0;
        end else if (hb_load) begin
            hops_from_sink <= disp_pkt.hops;
            e_min_r        <= disp_pkt.e_min;
            e_max_r        <= disp_pkt.e_max;
            e_threshold_r  <= disp_pkt.e_threshold;
        end
    end

    // cluster head if the advertisement names this node
    always_ff @(posedge clk) begin
        if (!nrst) begin
            role <= 1'b0;
        end else if (is_ch_adv) begin
            role <= (disp_pkt.ch_id == NODE_ID);
        end
    end

    // TDMA slot from the schedule
    always_ff @(posedge clk) begin
        if (!nrst) begin
            timeslot <= '0;
        end else if (is_sched) begin
            timeslot <= disp_pkt.timeslot;
        end
    end

    // battery check, one cycle behind energy
    always_ff @(posedge clk) begin
        if (!nrst) begin
            low_energy <= 1'b0;
        end else begin
            low_energy <= (energy < e_threshold_r);
        end
    end

    // latched window and hops for the Q block
    assign cfg = '{
        e_min:          e_min_r,
        e_max:          e_max_r,
        hops_from_sink: hops_from_sink
    };

    // role only moves right after a CH_ADV was dispatched
    a_role_from_ch_adv: assert property (
        @(posedge clk) disable iff (!nrst)
        $changed(role) |-> $past(is_ch_adv)
    );

endmodule

// File: q_learning/q_value_calc.sv
`timescale 1ns/1ps

module q_value_calc #(
    parameter int ALPHA_SHIFT = 2,
    parameter int HOP_SHIFT   = 4
) (
    input  logic                         clk,
    input  logic                         nrst,
    input  wsn_pkg::node_cfg_t           cfg,
    input  logic [wsn_pkg::WORD_W-1:0]   energy,
    output logic [wsn_pkg::WORD_W-1:0]   q_value
);
    import wsn_pkg::*;

    localparam int PEN_W = WORD_W + HOP_SHIFT;

    logic [WORD_W-1:0]         e_hi;
    logic [WORD_W-1:0]         e_clamp;
    logic [WORD_W-1:0]         reward;
    logic [WORD_W-1:0]         win_span;
    logic [PEN_W-1:0]          penalty;
    logic [WORD_W-1:0]         target;
    logic signed [WORD_W:0]    diff;
    logic signed [WORD_W:0]    step;
    logic signed [WORD_W:0]    q_sum;
    logic [WORD_W-1:0]         q_next;

    // clamp energy into [e_min, e_max]
    // an inverted window collapses to e_min
    assign e_hi    = (energy > cfg.e_max) ? cfg.e_max : energy;
    assign e_clamp = (e_hi < cfg.e_min) ? cfg.e_min : e_hi;
    assign reward  = e_clamp - cfg.e_min;

    // width of the latched window, zero if inverted
    assign win_span = (cfg.e_max > cfg.e_min) ? cfg.e_max - cfg.e_min : '0;

    // hop penalty, saturate the target at zero
    assign penalty = {cfg.hops_from_sink, {HOP_SHIFT{1'b0}}};
    assign target  = (PEN_W'(reward) > penalty) ? reward - WORD_W'(penalty) : '0;

    // move a fraction 1/2^ALPHA_SHIFT of the way to the target
    assign diff  = $signed({1'b0, target}) - $signed({1'b0, q_value});
    assign step  = diff >>> ALPHA_SHIFT;
    assign q_sum = $signed({1'b0, q_value}) + step;

    // result lies between q_value and target, so the sign bit is clear
    assign q_next = q_sum[WORD_W-1:0];

    always_ff @(posedge clk) begin
        if (!nrst) begin
            q_value <= '0;
        end else begin
            q_value <= q_next;
        end
    end

    // Q stays inside the window that was latched when it was computed
    a_q_in_window: assert property (
        @(posedge clk) disable iff (!nrst)
        q_value <= $past(win_span)
    );

endmodule

// File: verilog/wsn_node_top.sv
`timescale 1ns/1ps

module wsn_node_top #(
    parameter logic [wsn_pkg::WORD_W-1:0] NODE_ID = 16'h000C,
    parameter int RX_DEPTH       = 4,
    parameter int TX_CREDITS_MAX = 4,
    parameter int ALPHA_SHIFT    = 2,
    parameter int HOP_SHIFT      = 4
) (
    input  logic                         clk,
    input  logic                         nrst,
    // receive link from the radio side
    input  logic                         rx_valid,
    input  wsn_pkg::wsn_pkt_t            rx_pkt,
    output logic                         rx_credit,
    // transmit link to the next hop
    input  logic                         tx_credit,
    output logic                         tx_valid,
    output wsn_pkg::wsn_pkt_t            tx_pkt,
    input  logic [wsn_pkg::WORD_W-1:0]   energy,
    output logic [wsn_pkg::WORD_W-1:0]   hops_from_sink,
    output logic [wsn_pkg::WORD_W-1:0]   timeslot,
    output logic                         role,
    output logic                         low_energy,
    output logic [wsn_pkg::WORD_W-1:0]   q_value
);
    import wsn_pkg::*;

    logic        disp_valid;
    wsn_pkt_t    disp_pkt;
    node_cfg_t   cfg;

    pkt_rx_queue #(
        .RX_DEPTH       (RX_DEPTH),
        .TX_CREDITS_MAX (TX_CREDITS_MAX)
    ) rx_queue_i (
        .clk        (clk),
        .nrst       (nrst),
        .rx_valid   (rx_valid),
        .rx_pkt     (rx_pkt),
        .rx_credit  (rx_credit),
        .tx_credit  (tx_credit),
        .tx_valid   (tx_valid),
        .tx_pkt     (tx_pkt),
        .disp_valid (disp_valid),
        .disp_pkt   (disp_pkt)
    );

    node_info #(
        .NODE_ID (NODE_ID)
    ) node_info_i (
        .clk            (clk),
        .nrst           (nrst),
        .disp_valid     (disp_valid),
        .disp_pkt       (disp_pkt),
        .energy         (energy),
        .cfg            (cfg),
        .hops_from_sink (hops_from_sink),
        .timeslot       (timeslot),
        .role           (role),
        .low_energy     (low_energy)
    );

    q_value_calc #(
        .ALPHA_SHIFT (ALPHA_SHIFT),
        .HOP_SHIFT   (HOP_SHIFT)
    ) q_calc_i (
        .clk     (clk),
        .nrst    (nrst),
        .cfg     (cfg),
        .energy  (energy),
        .q_value (q_value)
    );

endmodule

// File: tb/wsn_node_tb.sv
`timescale 1ns/1ps

module wsn_node_tb;
    import wsn_pkg::*;

    localparam logic [WORD_W-1:0] NODE_ID = 16'h000C;
    localparam int RX_DEPTH       = 4;
    localparam int TX_CREDITS_MAX = 4;
    localparam int ALPHA_SHIFT    = 2;
    localparam int HOP_SHIFT      = 4;
    localparam int TIMEOUT        = 300;

    logic              clk;
    logic              nrst;
    logic              rx_valid;
    wsn_pkt_t          rx_pkt;
    logic              rx_credit;
    logic              tx_credit;
    logic              tx_valid;
    wsn_pkt_t          tx_pkt;
    logic [WORD_W-1:0] energy;
    logic [WORD_W-1:0] hops_from_sink;
    logic [WORD_W-1:0] timeslot;
    logic              role;
    logic              low_energy;
    logic [WORD_W-1:0] q_value;

    int seed = 32'h0095_5561;

    // sender credits, credits owed by the next hop, check windows
    int   s_cred;
    int   pend_ret;
    logic ret_en;
    logic stall_chk;
    logic settle_chk;

    // reference model of the node
    wsn_pkt_t          rx_exp[$];
    wsn_pkt_t          data_exp[$];
    wsn_pkt_t          m_next_fwd;
    logic              m_fwd_pend;
    logic              m_lock;
    logic              m_role;
    logic              m_low;
    logic [WORD_W-1:0] m_hops;
    logic [WORD_W-1:0] m_slot;
    logic [WORD_W-1:0] m_emin;
    logic [WORD_W-1:0] m_emax;
    logic [WORD_W-1:0] m_thr;
    int                m_q;
    int                m_tgt;
    int                m_txc;

    wsn_node_top #(
        .NODE_ID        (NODE_ID),
        .RX_DEPTH       (RX_DEPTH),
        .TX_CREDITS_MAX (TX_CREDITS_MAX),
        .ALPHA_SHIFT    (ALPHA_SHIFT),
        .HOP_SHIFT      (HOP_SHIFT)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // clamped energy minus window floor, less the hop penalty, floored at zero
    function automatic int q_target(int e, int lo, int hi, int hops);
        int ec;
        int t;
        ec = (e > hi) ? hi : e;
        ec = (ec < lo) ? lo : ec;
        t  = ec - lo - (hops << HOP_SHIFT);
        return (t > 0) ? t : 0;
    endfunction

    function automatic wsn_pkt_t rand_pkt(input pkt_type_e t);
        wsn_pkt_t p;
        p = 115'({$random(seed), $random(seed), $random(seed), $random(seed)});
        p.pkt_type = t;
        return p;
    endfunction

    task automatic apply_disp(input wsn_pkt_t p);
        case (p.pkt_type)
            PKT_HEARTBEAT: begin
                if (!m_lock) begin
                    m_hops = p.hops;
                    m_emin = p.e_min;
                    m_emax = p.e_max;
                    m_thr  = p.e_threshold;
                    m_lock = 1'b1;
                end
            end
            PKT_DATA:   m_lock = 1'b0;
            PKT_CH_ADV: m_role = (p.ch_id == NODE_ID);
            PKT_SCHED:  m_slot = p.timeslot;
            default:    ;
        endcase
    endtask

    // model steps on the values held before each edge
    always @(posedge clk) begin
        wsn_pkt_t p;
        if (!nrst) begin
            {m_lock, m_role, m_low} = '0;
            {m_hops, m_slot, m_emin, m_emax, m_thr} = '0;
            m_q   = 0;
            m_tgt = 0;
            m_txc = TX_CREDITS_MAX;
        end else begin
            m_tgt = q_target(energy, m_emin, m_emax, m_hops);
            m_q   = m_q + ((m_tgt - m_q) >>> ALPHA_SHIFT);
            m_low = (energy < m_thr);
            m_txc = m_txc + int'(tx_credit) - int'(tx_valid);
            if (tx_valid && data_exp.size() > 0) p = data_exp.pop_front();
            // rx_credit marks the cycle the popped head reaches node_info
            if (rx_credit && rx_exp.size() > 0) begin
                p = rx_exp.pop_front();
                apply_disp(p);
            end
        end
        m_fwd_pend = (data_exp.size() > 0);
        if (m_fwd_pend) m_next_fwd = data_exp[0];
    end

    always @(posedge clk) begin
        if (!nrst) s_cred = RX_DEPTH;
        else if (rx_credit) s_cred = s_cred + 1;
    end

    // next hop returns one credit per forwarded packet while enabled
    always @(posedge clk) begin
        if (!nrst) pend_ret = 0;
        else if (tx_valid) pend_ret = pend_ret + 1;
        #1;
        if (ret_en && pend_ret > 0) begin
            tx_credit = 1'b1;
            pend_ret  = pend_ret - 1;
        end else begin
            tx_credit = 1'b0;
        end
    end

    a_hops: assert property (@(posedge clk) disable iff (!nrst) hops_from_sink == m_hops)
        else report_fail($sformatf("[ERROR] hops_from_sink got %h expected %h",
            $sampled(hops_from_sink), $sampled(m_hops)));
    a_slot: assert property (@(posedge clk) disable iff (!nrst) timeslot == m_slot)
        else report_fail($sformatf("[ERROR] timeslot got %h expected %h",
            $sampled(timeslot), $sampled(m_slot)));
    a_role: assert property (@(posedge clk) disable iff (!nrst) role == m_role)
        else report_fail($sformatf("[ERROR] role got %h expected %h",
            $sampled(role), $sampled(m_role)));
    a_low: assert property (@(posedge clk) disable iff (!nrst) low_energy == m_low)
        else report_fail($sformatf("[ERROR] low_energy got %h expected %h",
            $sampled(low_energy), $sampled(m_low)));
    a_q: assert property (@(posedge clk) disable iff (!nrst) int'(q_value) == m_q)
        else report_fail($sformatf("[ERROR] q_value got %h expected %h",
            $sampled(q_value), $sampled(m_q)));
    a_settle: assert property (@(posedge clk) disable iff (!nrst)
        settle_chk |-> int'(q_value) <= m_tgt && m_tgt - int'(q_value) < (1 << ALPHA_SHIFT))
        else report_fail($sformatf("[ERROR] q_value got %h target %h",
            $sampled(q_value), $sampled(m_tgt)));
    // credits held before the send edge exclude a return landing on that edge
    a_tx_credit: assert property (@(posedge clk) disable iff (!nrst)
        tx_valid |-> m_txc > int'($past(tx_credit)))
        else report_fail($sformatf("[ERROR] tx_valid with node credits %h",
            $sampled(m_txc) - int'($past(tx_credit))));
    a_tx_order: assert property (@(posedge clk) disable iff (!nrst)
        tx_valid |-> m_fwd_pend && tx_pkt == m_next_fwd)
        else report_fail($sformatf("[ERROR] tx_pkt got %h expected %h",
            $sampled(tx_pkt), $sampled(m_next_fwd)));
    a_stall: assert property (@(posedge clk) disable iff (!nrst)
        stall_chk |-> !tx_valid && !rx_credit)
        else report_fail($sformatf("[ERROR] tx_valid %h rx_credit %h during stall",
            $sampled(tx_valid), $sampled(rx_credit)));
    a_rx_cred: assert property (@(posedge clk) disable iff (!nrst) s_cred <= RX_DEPTH)
        else report_fail($sformatf("[ERROR] rx_credit returned too often, sender holds %h",
            $sampled(s_cred)));

    task automatic send_pkt(input wsn_pkt_t p);
        int n;
        n = 0;
        while (s_cred == 0) begin
            if (n == TIMEOUT) report_fail("timed out waiting for a receive credit");
            @(posedge clk);
            #1;
            n++;
        end
        rx_valid = 1'b1;
        rx_pkt   = p;
        s_cred   = s_cred - 1;
        rx_exp.push_back(p);
        if (p.pkt_type == PKT_DATA) data_exp.push_back(p);
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic send_heartbeat(input int hops, input int lo, input int hi, input int thr);
        wsn_pkt_t p;
        p = rand_pkt(PKT_HEARTBEAT);
        p.hops        = 16'(hops);
        p.e_min       = 16'(lo);
        p.e_max       = 16'(hi);
        p.e_threshold = 16'(thr);
        send_pkt(p);
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (rx_exp.size() != 0 || data_exp.size() != 0 || pend_ret != 0) begin
            if (n == TIMEOUT) report_fail("timed out waiting for the queue to drain");
            @(posedge clk);
            #1;
            n++;
        end
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic run_cycles(input int cycles);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    initial begin
        wsn_pkt_t p;
        int n;
        nrst       = 1'b0;
        rx_valid   = 1'b0;
        rx_pkt     = '0;
        tx_credit  = 1'b0;
        energy     = 16'd500;
        ret_en     = 1'b1;
        stall_chk  = 1'b0;
        settle_chk = 1'b0;
        run_cycles(10);
        nrst = 1'b1;

        // first heartbeat locks, second is ignored, data opens a new round
        send_heartbeat(3, 100, 900, 300);
        wait_idle();
        send_heartbeat(7, 200, 600, 450);
        send_pkt(rand_pkt(PKT_DATA));
        send_heartbeat(2, 50, 1000, 400);
        wait_idle();

        p = rand_pkt(PKT_CH_ADV);
        p.ch_id = NODE_ID;
        send_pkt(p);
        wait_idle();
        p = rand_pkt(PKT_CH_ADV);
        p.ch_id = NODE_ID ^ 16'h0100;
        send_pkt(p);
        send_pkt(rand_pkt(PKT_SCHED));
        send_pkt(rand_pkt(PKT_JOIN));
        send_pkt(rand_pkt(PKT_JOIN));
        wait_idle();

        // energy wanders across the 400 threshold
        repeat (30) begin
            energy = 16'(300 + $unsigned($random(seed)) % 200);
            run_cycles(1);
        end

        // Q settles from below, then decays to zero under the hop penalty
        energy = 16'd700;
        run_cycles(40);
        settle_chk = 1'b1;
        run_cycles(5);
        settle_chk = 1'b0;
        energy = 16'd20;
        run_cycles(40);
        settle_chk = 1'b1;
        run_cycles(5);
        settle_chk = 1'b0;
        energy = 16'd650;

        // next hop withholds credits, data backs up into the FIFO
        n = 0;
        while (m_txc != TX_CREDITS_MAX) begin
            if (n == TIMEOUT) report_fail("transmit credits never returned to full");
            run_cycles(1);
            n++;
        end
        ret_en = 1'b0;
        repeat (TX_CREDITS_MAX + RX_DEPTH) send_pkt(rand_pkt(PKT_DATA));
        n = 0;
        while (data_exp.size() != RX_DEPTH || s_cred != 0) begin
            if (n == TIMEOUT) report_fail("queue did not fill while credits were withheld");
            run_cycles(1);
            n++;
        end
        stall_chk = 1'b1;
        run_cycles(10);
        stall_chk = 1'b0;
        ret_en = 1'b1;
        wait_idle();
        n = 0;
        while (s_cred != RX_DEPTH) begin
            if (n == TIMEOUT) report_fail("receive credits never returned to the sender");
            run_cycles(1);
            n++;
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: wsn_node.f
common/wsn_pkg.sv
verilog/pkt_rx_queue.sv
node_info/node_info.sv
q_learning/q_value_calc.sv
verilog/wsn_node_top.sv
tb/wsn_node_tb.sv
